//--- logic/tracker_params.svh
`ifndef TRACKER_PARAMS_SVH
`define TRACKER_PARAMS_SVH

// ==============================
// frame geometry
// ==============================
`define FRAME_W 64 // pixels per line
`define FRAME_H 48 // lines per frame

// ==============================
// search grid
// ==============================
`define WIN_SIZE 8 // window edge in pixels
`define GRID_N 4   // windows per side
`define NUM_WIN (`GRID_N * `GRID_N)

// top bit of blue margin taken for the 2-bit grade
`define GRADE_MSB 7

`endif

//--- logic/tracker_pkg.sv
package tracker_pkg;

  // ==============================
  // vector types
  // ==============================

  // raster coordinate, H or V
  typedef logic [9:0] coord_t;

  // pixel grade, 0 = no blue dominance
  typedef logic [1:0] grade_t;

  // window sum, at most 64 pixels x grade 3
  typedef logic [7:0] winSum_t;

  // row-major window index
  typedef logic [3:0] winIdx_t;

  // ==============================
  // peak selector FSM
  // ==============================
  typedef enum logic [1:0] {
    IDLE,   // accumulating frame
    SCAN,   // settle cycle then one window per cycle
    UPDATE  // report point, move region
  } selState_t;

endpackage

//--- logic/gradeStream_if.sv
// graded pixel stream with raster position
interface gradeStream_if;

  tracker_pkg::grade_t grade;
  logic                gradeVal;  // one cycle per accepted pixel
  tracker_pkg::coord_t posH;
  tracker_pkg::coord_t posV;
  logic                frameEnd;  // with gradeVal of last pixel

  modport src (
    output grade, gradeVal, posH, posV, frameEnd
  );

  modport snk (
    input grade, gradeVal, posH, posV, frameEnd
  );

endinterface

//--- logic/windowBus_if.sv
`include "tracker_params.svh"

// region control out to the bank, window sums back to the selector
interface windowBus_if;

  tracker_pkg::coord_t  regionH;           // grid origin H
  tracker_pkg::coord_t  regionV;           // grid origin V
  logic                 clear;             // zero all sums
  tracker_pkg::winSum_t sums [`NUM_WIN];   // row-major

  modport bank (
    input  regionH,
    input  regionV,
    input  clear,
    output sums
  );

  modport sel (
    output regionH,
    output regionV,
    output clear,
    input  sums
  );

endinterface

//--- logic/pixelFrontEnd.sv
`include "tracker_params.svh"

module pixelFrontEnd (
  input  logic        i_clk,
  input  logic        i_rst_n,
  input  logic [23:0] i_rgb,
  input  logic        i_pixelVal,
  gradeStream_if.src  o_gs
);

  logic [7:0] red;
  logic [7:0] green;
  logic [7:0] blue;
  logic [7:0] marginR;
  logic [7:0] marginG;
  logic [7:0] marginMin;
  tracker_pkg::coord_t hCnt;
  tracker_pkg::coord_t vCnt;
  logic lastCol;
  logic lastRow;

  // ==============================
  // grading
  // ==============================
  assign red   = i_rgb[23:16];
  assign green = i_rgb[15:8];
  assign blue  = i_rgb[7:0];

  assign marginR   = (blue > red) ? blue - red : 8'd0;
  assign marginG   = (blue > green) ? blue - green : 8'd0;
  assign marginMin = (marginR < marginG) ? marginR : marginG; // weaker margin decides

  assign lastCol = (hCnt == tracker_pkg::coord_t'(`FRAME_W - 1));
  assign lastRow = (vCnt == tracker_pkg::coord_t'(`FRAME_H - 1));

  // ==============================
  // raster counters
  // ==============================
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      hCnt <= '0;
      vCnt <= '0;
    end else if (i_pixelVal) begin
      if (lastCol) begin
        hCnt <= '0;
        vCnt <= lastRow ? '0 : vCnt + 1'b1; // wrap at frame end
      end else begin
        hCnt <= hCnt + 1'b1;
      end
    end
  end

  // stream strobes
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_gs.gradeVal <= 1'b0;
      o_gs.frameEnd <= 1'b0;
    end else begin
      o_gs.gradeVal <= i_pixelVal;
      o_gs.frameEnd <= i_pixelVal && lastCol && lastRow;
    end
  end

  // grade and position of the accepted pixel
  always_ff @(posedge i_clk) begin
    if (i_pixelVal) begin
      o_gs.grade <= marginMin[`GRADE_MSB:`GRADE_MSB-1];
      o_gs.posH  <= hCnt;
      o_gs.posV  <= vCnt;
    end
  end

endmodule

//--- logic/windowAccum.sv
`include "tracker_params.svh"

module windowAccum (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_clear,
  input  tracker_pkg::grade_t  i_grade,
  input  logic                 i_gradeVal,
  input  tracker_pkg::coord_t  i_posH,
  input  tracker_pkg::coord_t  i_posV,
  input  tracker_pkg::coord_t  i_originH,
  input  tracker_pkg::coord_t  i_originV,
  output tracker_pkg::winSum_t o_sum
);

  tracker_pkg::coord_t endH;
  tracker_pkg::coord_t endV;
  logic inWin;

  // window spans [origin, origin + WIN_SIZE) on both axes
  assign endH = i_originH + tracker_pkg::coord_t'(`WIN_SIZE);
  assign endV = i_originV + tracker_pkg::coord_t'(`WIN_SIZE);

  assign inWin = (i_posH >= i_originH) && (i_posH < endH) &&
                 (i_posV >= i_originV) && (i_posV < endV);

  // ==============================
  // accumulator
  // ==============================
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_sum <= '0;
    end else if (i_clear) begin
      o_sum <= '0; // new frame
    end else if (i_gradeVal && inWin) begin
      // 64 pixels x 3 never wraps 8 bits
      o_sum <= o_sum + tracker_pkg::winSum_t'(i_grade);
    end
  end

endmodule

//--- logic/windowBank.sv
`include "tracker_params.svh"

module windowBank (
  input  logic        i_clk,
  input  logic        i_rst_n,
  gradeStream_if.snk  i_gs,
  windowBus_if.bank   io_win
);

  // ==============================
  // window grid
  // ==============================
  genvar k;
  generate
    for (k = 0; k < `NUM_WIN; k = k + 1) begin : winGen
      tracker_pkg::coord_t originH;
      tracker_pkg::coord_t originV;

      // column from k mod N, row from k div N
      assign originH = io_win.regionH +
                       tracker_pkg::coord_t'((k % `GRID_N) * `WIN_SIZE);
      assign originV = io_win.regionV +
                       tracker_pkg::coord_t'((k / `GRID_N) * `WIN_SIZE);

      windowAccum windowAccum_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_clear    (io_win.clear),
        .i_grade    (i_gs.grade),
        .i_gradeVal (i_gs.gradeVal),
        .i_posH     (i_gs.posH),
        .i_posV     (i_gs.posV),
        .i_originH  (originH),
        .i_originV  (originV),
        .o_sum      (io_win.sums[k])
      );
    end
  endgenerate

endmodule

//--- logic/peakSelector.sv
`include "tracker_params.svh"

module peakSelector (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_frameEnd,
  windowBus_if.sel             io_win,
  output tracker_pkg::coord_t  o_pointH,
  output tracker_pkg::coord_t  o_pointV,
  output tracker_pkg::winSum_t o_peakSum,
  output logic                 o_valid
);

  localparam int SPAN      = `WIN_SIZE * `GRID_N;  // grid edge in pixels
  localparam int HALF_SPAN = SPAN / 2;
  localparam int MAX_H     = `FRAME_W - SPAN;      // highest legal origin
  localparam int MAX_V     = `FRAME_H - SPAN;
  localparam int LAST_IDX  = `NUM_WIN - 1;

  tracker_pkg::selState_t state;
  logic                   settle;   // first SCAN cycle, last sum landing
  tracker_pkg::winIdx_t   scanIdx;
  tracker_pkg::winIdx_t   bestIdx;
  tracker_pkg::winSum_t   bestSum;
  tracker_pkg::coord_t    winPointH;
  tracker_pkg::coord_t    winPointV;

  // centre the grid on the point, kept inside the frame
  function automatic tracker_pkg::coord_t clampOrigin(
    input tracker_pkg::coord_t point,
    input tracker_pkg::coord_t maxOrigin
  );
    tracker_pkg::coord_t shifted;
    shifted = point - tracker_pkg::coord_t'(HALF_SPAN);
    if (point < tracker_pkg::coord_t'(HALF_SPAN)) begin
      return '0;
    end else if (shifted > maxOrigin) begin
      return maxOrigin;
    end
    return shifted;
  endfunction

  // top-left pixel of the winning window
  assign winPointH = io_win.regionH +
                     tracker_pkg::coord_t'((bestIdx % `GRID_N) * `WIN_SIZE);
  assign winPointV = io_win.regionV +
                     tracker_pkg::coord_t'((bestIdx / `GRID_N) * `WIN_SIZE);

  // ==============================
  // scan FSM
  // ==============================
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state   <= tracker_pkg::IDLE;
      settle  <= 1'b0;
      scanIdx <= '0;
      bestIdx <= '0;
      bestSum <= '0;
    end else begin
      case (state)
        tracker_pkg::IDLE: begin
          if (i_frameEnd) begin
            state   <= tracker_pkg::SCAN;
            settle  <= 1'b1;
            scanIdx <= '0;
            bestIdx <= '0;
            bestSum <= '0;
          end
        end
        tracker_pkg::SCAN: begin
          if (settle) begin
            settle <= 1'b0;
          end else begin
            // strict compare keeps the lowest index on ties
            if (io_win.sums[scanIdx] > bestSum) begin
              bestSum <= io_win.sums[scanIdx];
              bestIdx <= scanIdx;
            end
            if (scanIdx == tracker_pkg::winIdx_t'(LAST_IDX)) begin
              state <= tracker_pkg::UPDATE;
            end else begin
              scanIdx <= scanIdx + 1'b1;
            end
          end
        end
        tracker_pkg::UPDATE: state <= tracker_pkg::IDLE;
        default:             state <= tracker_pkg::IDLE;
      endcase
    end
  end

  // ==============================
  // result and region update
  // ==============================
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_pointH       <= '0;
      o_pointV       <= '0;
      o_peakSum      <= '0;
      o_valid        <= 1'b0;
      io_win.clear   <= 1'b0;
      io_win.regionH <= tracker_pkg::coord_t'(MAX_H / 2); // centred grid
      io_win.regionV <= tracker_pkg::coord_t'(MAX_V / 2);
    end else begin
      o_valid      <= (state == tracker_pkg::UPDATE);
      io_win.clear <= (state == tracker_pkg::UPDATE);
      if (state == tracker_pkg::UPDATE) begin
        o_pointH       <= winPointH;
        o_pointV       <= winPointV;
        o_peakSum      <= bestSum;
        io_win.regionH <= clampOrigin(winPointH, tracker_pkg::coord_t'(MAX_H));
        io_win.regionV <= clampOrigin(winPointV, tracker_pkg::coord_t'(MAX_V));
      end
    end
  end

endmodule

//--- logic/blueTracker.sv
module blueTracker (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic [23:0]          i_rgb,      // R high, B low
  input  logic                 i_pixelVal,
  output tracker_pkg::coord_t  o_pointH,
  output tracker_pkg::coord_t  o_pointV,
  output tracker_pkg::winSum_t o_peakSum,
  output logic                 o_valid
);

  // ==============================
  // internal buses
  // ==============================
  gradeStream_if gsIf ();
  windowBus_if   winIf ();

  // grading and raster position
  pixelFrontEnd pixelFrontEnd_i (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_rgb      (i_rgb),
    .i_pixelVal (i_pixelVal),
    .o_gs       (gsIf.src)
  );

  // grid of window sums
  windowBank windowBank_i (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_gs    (gsIf.snk),
    .io_win  (winIf.bank)
  );

  // frame-end argmax and recentring
  peakSelector peakSelector_i (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_frameEnd (gsIf.frameEnd),
    .io_win     (winIf.sel),
    .o_pointH   (o_pointH),
    .o_pointV   (o_pointV),
    .o_peakSum  (o_peakSum),
    .o_valid    (o_valid)
  );

endmodule

//--- tb/blueTracker_assertions.sv
`include "tracker_params.svh"

module blueTracker_assertions (
  input logic i_clk,
  input logic i_rst_n,
  input logic i_pixelVal,
  input logic i_valid
);

  localparam int LAST_PIX = `FRAME_W * `FRAME_H - 1;

  int unsigned pixCnt;  // pixels taken in the current frame
  logic        inGap;   // last pixel taken and result not out yet

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pixCnt <= 0;
      inGap  <= 1'b0;
    end else begin
      if (i_valid) begin
        inGap <= 1'b0;
      end
      if (i_pixelVal) begin
        if (pixCnt == LAST_PIX) begin
          pixCnt <= 0;
          inGap  <= 1'b1;
        end else begin
          pixCnt <= pixCnt + 1;
        end
      end
    end
  end

  // ==============================
  // properties
  // ==============================
  validSinglePulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_valid |=> !i_valid)
    else $error("o_valid stayed high for two cycles");

  // a result needs a whole frame taken since reset
  validAfterFrame: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_valid |-> inGap)
    else $error("o_valid high without a completed frame");

  // no pixels while the selector scans
  quietDuringScan: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (inGap && !i_valid) |-> !i_pixelVal)
    else $error("pixel offered between frame end and o_valid");

endmodule

bind blueTracker blueTracker_assertions blueTracker_assertions_i (
  .i_clk      (i_clk),
  .i_rst_n    (i_rst_n),
  .i_pixelVal (i_pixelVal),
  .i_valid    (o_valid)
);

//--- tb/tb_blueTracker.sv
`include "tracker_params.svh"

module tb_blueTracker;

  localparam int SPAN       = `WIN_SIZE * `GRID_N;  // grid edge in pixels
  localparam int NUM_PIX    = `FRAME_W * `FRAME_H;
  localparam int NUM_FRAMES = 11;                   // frames over all tests
  localparam int MAX_CYCLES = NUM_FRAMES * (NUM_PIX * 2 + 40) + 100;

  typedef logic [23:0] frame_t [`FRAME_H][`FRAME_W];

  logic                 i_clk;
  logic                 i_rst_n;
  logic [23:0]          i_rgb;
  logic                 i_pixelVal;
  tracker_pkg::coord_t  o_pointH;
  tracker_pkg::coord_t  o_pointV;
  tracker_pkg::winSum_t o_peakSum;
  logic                 o_valid;

  frame_t frame;            // pixels of the frame being streamed
  int     regionH;          // testbench copy of the grid origin
  int     regionV;
  int     expH[$];
  int     expV[$];
  int     expSum[$];
  int     resultsSeen;
  int     checkCount;
  int     errCount;
  int     testCount;
  int     failedTests;
  int     testErrBase;
  int     cycleCount;
  string  testName;

  blueTracker blueTracker_i (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_rgb      (i_rgb),
    .i_pixelVal (i_pixelVal),
    .o_pointH   (o_pointH),
    .o_pointV   (o_pointV),
    .o_peakSum  (o_peakSum),
    .o_valid    (o_valid)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  // run limit
  initial begin
    cycleCount = 0;
    while (cycleCount < MAX_CYCLES) begin
      @(posedge i_clk);
      cycleCount++;
    end
    $display("timeout: run stopped after %0d cycles waiting for a result", cycleCount);
    $display("Testbench failed");
    $finish;
  end

  // ==============================
  // reference model
  // ==============================
  function automatic int gradeOf(input logic [23:0] rgb);
    int r;
    int g;
    int b;
    int bR;
    int bG;
    int m;
    r  = int'(rgb[23:16]);
    g  = int'(rgb[15:8]);
    b  = int'(rgb[7:0]);
    bR = (b > r) ? b - r : 0;
    bG = (b > g) ? b - g : 0;
    m  = (bR < bG) ? bR : bG;
    return (m >> (`GRADE_MSB - 1)) % 4; // two bits from GRADE_MSB down
  endfunction

  function automatic int nextOrigin(input int point, input int maxOrigin);
    int o;
    o = point - SPAN / 2;
    if (o < 0) begin
      o = 0;
    end else if (o > maxOrigin) begin
      o = maxOrigin;
    end
    return o;
  endfunction

  function automatic void refTrack(input frame_t f, input int regH, input int regV,
                                   output int pointH, output int pointV, output int peak);
    int sum;
    int bestK;
    int bestSum;
    int h0;
    int v0;
    bestK   = 0;
    bestSum = -1;
    for (int k = 0; k < `NUM_WIN; k++) begin
      h0  = regH + (k % `GRID_N) * `WIN_SIZE;
      v0  = regV + (k / `GRID_N) * `WIN_SIZE;
      sum = 0;
      for (int v = 0; v < `WIN_SIZE; v++) begin
        for (int h = 0; h < `WIN_SIZE; h++) begin
          sum += gradeOf(f[v0 + v][h0 + h]);
        end
      end
      if (sum > bestSum) begin // first of equals stays
        bestSum = sum;
        bestK   = k;
      end
    end
    pointH = regH + (bestK % `GRID_N) * `WIN_SIZE;
    pointV = regV + (bestK / `GRID_N) * `WIN_SIZE;
    peak   = bestSum;
  endfunction

  // ==============================
  // helpers
  // ==============================
  task automatic checkVal(input string name, input int actual, input int expected);
    checkCount++;
    if (actual != expected) begin
      $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, actual, expected);
      errCount++;
    end
  endtask

  task automatic startTest(input string name);
    testName    = name;
    testErrBase = errCount;
    testCount++;
  endtask

  task automatic finishTest();
    if (errCount > testErrBase) begin
      failedTests++;
      $display("test %0d (%s): FAIL, %0d errors", testCount, testName,
               errCount - testErrBase);
    end else begin
      $display("test %0d (%s): ok", testCount, testName);
    end
  endtask

  task automatic fillFrame(input logic [23:0] rgb);
    for (int v = 0; v < `FRAME_H; v++) begin
      for (int h = 0; h < `FRAME_W; h++) begin
        frame[v][h] = rgb;
      end
    end
  endtask

  task automatic fillRandom();
    for (int v = 0; v < `FRAME_H; v++) begin
      for (int h = 0; h < `FRAME_W; h++) begin
        frame[v][h] = 24'($urandom());
      end
    end
  endtask

  // window k of the current region
  task automatic paintWindow(input int k, input logic [23:0] rgb);
    int h0;
    int v0;
    h0 = regionH + (k % `GRID_N) * `WIN_SIZE;
    v0 = regionV + (k / `GRID_N) * `WIN_SIZE;
    for (int v = 0; v < `WIN_SIZE; v++) begin
      for (int h = 0; h < `WIN_SIZE; h++) begin
        frame[v0 + v][h0 + h] = rgb;
      end
    end
  endtask

  // streams one frame from a falling edge and waits for its result
  task automatic runFrame(input bit withGaps);
    int pH;
    int pV;
    int peak;
    int seenBefore;
    refTrack(frame, regionH, regionV, pH, pV, peak);
    expH.push_back(pH);
    expV.push_back(pV);
    expSum.push_back(peak);
    regionH    = nextOrigin(pH, `FRAME_W - SPAN);
    regionV    = nextOrigin(pV, `FRAME_H - SPAN);
    seenBefore = resultsSeen;
    for (int v = 0; v < `FRAME_H; v++) begin
      for (int h = 0; h < `FRAME_W; h++) begin
        if (withGaps && $urandom_range(3) == 0) begin
          i_pixelVal = 1'b0; // one idle cycle
          @(negedge i_clk);
        end
        i_rgb      = frame[v][h];
        i_pixelVal = 1'b1;
        @(negedge i_clk);
      end
    end
    i_pixelVal = 1'b0;
    while (resultsSeen == seenBefore) begin
      @(negedge i_clk);
    end
  endtask

  // compare each result against the oldest pending frame
  always @(negedge i_clk) begin
    if (i_rst_n && o_valid) begin
      if (expH.size() == 0) begin
        $display("o_valid pulsed at %0t with no frame pending", $time);
        errCount++;
      end else begin
        checkVal("o_pointH", int'(o_pointH), expH.pop_front());
        checkVal("o_pointV", int'(o_pointV), expV.pop_front());
        checkVal("o_peakSum", int'(o_peakSum), expSum.pop_front());
      end
      resultsSeen++;
    end
  end

  // ==============================
  // test sequence
  // ==============================
  initial begin
    i_rst_n     = 1'b0;
    i_rgb       = '0;
    i_pixelVal  = 1'b0;
    regionH     = (`FRAME_W - SPAN) / 2; // centred after reset
    regionV     = (`FRAME_H - SPAN) / 2;
    resultsSeen = 0;
    checkCount  = 0;
    errCount    = 0;
    testCount   = 0;
    failedTests = 0;
    void'($urandom(32'hfaed));
    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;

    startTest("idle after reset");
    repeat (40) begin
      @(negedge i_clk);
      checkVal("o_valid", int'(o_valid), 0);
    end
    checkVal("o_pointH", int'(o_pointH), 0);
    checkVal("o_pointV", int'(o_pointV), 0);
    checkVal("o_peakSum", int'(o_peakSum), 0);
    finishTest();

    startTest("grey frame");
    fillFrame(24'h808080);
    runFrame(1'b0);
    finishTest();

    startTest("blue window");
    fillFrame(24'hff0000);          // red background grades 0
    paintWindow(3, 24'h0000ff);
    runFrame(1'b0);
    finishTest();

    startTest("recentring to the right edge");
    repeat (4) begin
      fillFrame(24'hff0000);
      paintWindow(3, 24'h0000ff);   // right column pulls the region over
      runFrame(1'b0);
    end
    fillFrame(24'hff0000);
    paintWindow(0, 24'h0000ff);     // left edge of the clamped grid
    runFrame(1'b0);
    finishTest();

    startTest("tie between two blobs");
    fillFrame(24'hff0000);
    paintWindow(9, 24'h0000ff);
    paintWindow(6, 24'h0000ff);
    runFrame(1'b0);
    finishTest();

    startTest("random frames with gaps");
    repeat (3) begin
      fillRandom();
      runFrame(1'b1);
    end
    finishTest();

    $display("summary: %0d tests, %0d failed, %0d results, %0d checks, %0d errors",
             testCount, failedTests, resultsSeen, checkCount, errCount);
    if (errCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+logic
logic/tracker_pkg.sv
logic/gradeStream_if.sv
logic/windowBus_if.sv
logic/pixelFrontEnd.sv
logic/windowAccum.sv
logic/windowBank.sv
logic/peakSelector.sv
logic/blueTracker.sv
tb/blueTracker_assertions.sv
tb/tb_blueTracker.sv

//--- run.sh
#!/bin/sh
# build and run the blueTracker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module tb_blueTracker -o tb_blueTracker

./obj_dir/tb_blueTracker | tee sim.log

if grep -qx "Testbench passed" sim.log; then
  echo "simulation PASS"
else
  echo "simulation FAIL"
  exit 1
fi
